//--- hw/dcache_pkg.sv
// ==========================================================
// shared definitions for the data cache miss controller
// line geometry, queue depth, bus command and issuer state
// packed structs for cpu, bus and cache traffic
// ==========================================================
`default_nettype none

package dcache_pkg;

	// ==========================================================
	// geometry
	// ==========================================================
	localparam int ADR_W = 32;
	localparam int TID_W = 4;
	localparam int LINE_BYTES = 64;
	localparam int BEAT_BYTES = 16;
	localparam int BEATS = 4;
	localparam int QUEUE_DEPTH = 4;

	// derived widths
	localparam int LINE_W = LINE_BYTES * 8;
	localparam int BEAT_W = BEAT_BYTES * 8;
	localparam int QTR_W = $clog2(BEATS);
	localparam int QPTR_W = $clog2(QUEUE_DEPTH);

	// ==========================================================
	// enums
	// ==========================================================
	typedef enum logic [1:0] {
		CMD_NONE = 2'd0,
		CMD_LOAD = 2'd1,
		CMD_LINE_LOAD = 2'd2,
		CMD_STORE = 2'd3
	} bus_cmd_e;

	typedef enum logic [1:0] {
		ISSUE_IDLE = 2'd0,
		ISSUE_STORE = 2'd1,
		ISSUE_LOAD = 2'd2,
		ISSUE_WAIT = 2'd3
	} issue_state_e;

	// ==========================================================
	// traffic structs
	// ==========================================================
	// cpu line request, adr is line aligned
	typedef struct packed {
		logic cyc;
		logic [TID_W-1:0] tid;
		logic we;
		logic cacheable;
		logic [ADR_W-1:0] adr;
		logic [LINE_BYTES-1:0] sel;
		logic [LINE_W-1:0] dat;
	} line_req_t;

	// one 128-bit bus beat
	typedef struct packed {
		logic cyc;
		bus_cmd_e cmd;
		logic [TID_W-1:0] tid;
		logic [ADR_W-1:0] adr;
		logic [BEAT_BYTES-1:0] sel;
		logic [BEAT_W-1:0] dat;
	} bus_req_t;

	typedef struct packed {
		logic ack;
		logic [TID_W-1:0] tid;
		logic [ADR_W-1:0] adr;
		logic [BEAT_W-1:0] dat;
	} bus_resp_t;

	typedef struct packed {
		logic ack;
		logic [TID_W-1:0] tid;
		logic [LINE_W-1:0] dat;
	} cpu_resp_t;

	typedef struct packed {
		logic wr;
		logic [ADR_W-1:0] adr;
		logic [LINE_W-1:0] dat;
	} cache_wr_t;

	// issuer tells collector which id to expect for a quarter
	typedef struct packed {
		logic valid;
		logic [QTR_W-1:0] quarter;
		logic [TID_W-1:0] tid;
	} beat_note_t;

	// start of a line, one need bit per quarter
	typedef struct packed {
		logic valid;
		logic [BEATS-1:0] need;
	} line_need_t;

endpackage

`default_nettype wire

//--- hw/dcache_req_queue.sv
// ==========================================================
// in-order cpu request queue
// circular buffer with duplicate tid rejection and busy flag
// ==========================================================
`default_nettype none

module dcache_req_queue (
	input wire logic clk_i,
	input wire logic rst_i,
	input dcache_pkg::line_req_t cpu_req_i,
	input wire logic head_pop_i,
	output dcache_pkg::line_req_t head_o,
	output logic busy_o
);
	import dcache_pkg::*;

	// entry storage, payload only
	line_req_t entry_q [QUEUE_DEPTH];

	logic [QPTR_W-1:0] wr_ptr_q;
	logic [QPTR_W-1:0] rd_ptr_q;
	logic [QPTR_W:0] count_q;

	logic [QPTR_W-1:0] slot;
	logic dup;
	logic push;
	logic pop;

	// ==========================================================
	// admission
	// ==========================================================
	// walk the valid entries from the head and look for the same tid
	always_comb begin
		dup = 1'b0;
		slot = rd_ptr_q;
		for (int i = 0; i < QUEUE_DEPTH; i++) begin
			slot = rd_ptr_q + QPTR_W'(i);
			if ((QPTR_W + 1)'(i) < count_q && entry_q[slot].tid == cpu_req_i.tid)
				dup = 1'b1;
		end
	end

	assign busy_o = (count_q == (QPTR_W + 1)'(QUEUE_DEPTH));

	// a strobe while busy is dropped here as well
	assign push = cpu_req_i.cyc && !dup && !busy_o;
	assign pop = head_pop_i && (count_q != '0);

	// ==========================================================
	// pointers and count
	// ==========================================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end else begin
			if (push)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (pop)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			// simultaneous push and pop leaves the count alone
			case ({push, pop})
				2'b10: count_q <= count_q + 1'b1;
				2'b01: count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (push)
			entry_q[wr_ptr_q] <= cpu_req_i;
	end

	// head view, cyc tracks occupancy rather than the stored strobe
	always_comb begin
		head_o = entry_q[rd_ptr_q];
		head_o.cyc = (count_q != '0);
	end

endmodule

`default_nettype wire

//--- hw/dcache_beat_issuer.sv
// ==========================================================
// beat issuer
// splits the head request into 128-bit bus beats
// stores first, then loads, one tid per beat
// ==========================================================
`default_nettype none

module dcache_beat_issuer (
	input wire logic clk_i,
	input wire logic rst_i,
	input dcache_pkg::line_req_t head_i,
	input wire logic head_pop_i,
	input wire logic bus_full_i,
	output dcache_pkg::bus_req_t bus_req_o,
	output dcache_pkg::line_need_t line_need_o,
	output dcache_pkg::beat_note_t beat_note_o
);
	import dcache_pkg::*;

	issue_state_e state_q;
	// quarters still to issue in the current phase
	logic [BEATS-1:0] todo_q;
	logic [TID_W-1:0] tid_q;

	logic [BEATS-1:0] qsel_nz;
	logic [BEATS-1:0] need_mask;
	logic [BEATS-1:0] store_mask;
	logic [QTR_W-1:0] qtr;
	logic [BEATS-1:0] qtr_bit;
	logic last_beat;
	logic taken;
	logic defer_need;

	// ==========================================================
	// request decode
	// ==========================================================
	always_comb begin
		for (int q = 0; q < BEATS; q++)
			qsel_nz[q] = |head_i.sel[q*BEAT_BYTES +: BEAT_BYTES];
	end

	// cacheable lines always load the whole line
	assign need_mask = head_i.cacheable ? '1 : (head_i.we ? '0 : qsel_nz);
	assign store_mask = head_i.we ? qsel_nz : '0;

	// non-cacheable write with stores, announce the line after the last store
	assign defer_need = (need_mask == '0) && (store_mask != '0);

	// lowest pending quarter goes first
	always_comb begin
		qtr = '0;
		for (int q = BEATS - 1; q >= 0; q--)
			if (todo_q[q])
				qtr = QTR_W'(q);
	end

	assign qtr_bit = BEATS'(1) << qtr;
	assign last_beat = ((todo_q & ~qtr_bit) == '0);

	// ==========================================================
	// bus beat
	// ==========================================================
	always_comb begin
		bus_req_o = '0;
		bus_req_o.cyc = (state_q == ISSUE_STORE) || (state_q == ISSUE_LOAD);
		bus_req_o.tid = tid_q;
		bus_req_o.adr = head_i.adr + ADR_W'(qtr) * BEAT_BYTES;
		case (state_q)
			ISSUE_STORE: begin
				bus_req_o.cmd = CMD_STORE;
				bus_req_o.sel = head_i.sel[qtr*BEAT_BYTES +: BEAT_BYTES];
				bus_req_o.dat = head_i.dat[qtr*BEAT_W +: BEAT_W];
			end
			ISSUE_LOAD: begin
				bus_req_o.cmd = head_i.cacheable ? CMD_LINE_LOAD : CMD_LOAD;
				bus_req_o.sel = head_i.cacheable ? '1 :
					head_i.sel[qtr*BEAT_BYTES +: BEAT_BYTES];
			end
			default: bus_req_o.cmd = CMD_NONE;
		endcase
	end

	assign taken = bus_req_o.cyc && !bus_full_i;

	// note goes out in the same cycle the load beat is taken
	always_comb begin
		beat_note_o.valid = taken && (state_q == ISSUE_LOAD);
		beat_note_o.quarter = qtr;
		beat_note_o.tid = tid_q;
	end

	// ==========================================================
	// state machine
	// ==========================================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q <= ISSUE_IDLE;
			todo_q <= '0;
			tid_q <= TID_W'(1);
			line_need_o <= '0;
		end else begin
			line_need_o.valid <= 1'b0;
			// id 0 is never used, wrap to 1
			if (taken)
				tid_q <= (&tid_q) ? TID_W'(1) : tid_q + 1'b1;
			case (state_q)
				ISSUE_IDLE: begin
					if (head_i.cyc) begin
						if (!defer_need) begin
							line_need_o.valid <= 1'b1;
							line_need_o.need <= need_mask;
						end
						if (store_mask != '0) begin
							state_q <= ISSUE_STORE;
							todo_q <= store_mask;
						end else if (need_mask != '0) begin
							state_q <= ISSUE_LOAD;
							todo_q <= need_mask;
						end else begin
							state_q <= ISSUE_WAIT;
						end
					end
				end
				ISSUE_STORE: begin
					if (taken) begin
						todo_q <= todo_q & ~qtr_bit;
						if (last_beat) begin
							if (need_mask != '0) begin
								state_q <= ISSUE_LOAD;
								todo_q <= need_mask;
							end else begin
								// deferred start, empty need
								state_q <= ISSUE_WAIT;
								line_need_o.valid <= 1'b1;
								line_need_o.need <= '0;
							end
						end
					end
				end
				ISSUE_LOAD: begin
					if (taken) begin
						todo_q <= todo_q & ~qtr_bit;
						if (last_beat)
							state_q <= ISSUE_WAIT;
					end
				end
				default: begin
					// hold the head until merge releases it
					if (head_pop_i)
						state_q <= ISSUE_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/dcache_beat_collector.sv
// ==========================================================
// response collector
// matches bus acks by tid and fills the line buffer
// ==========================================================
`default_nettype none

module dcache_beat_collector (
	input wire logic clk_i,
	input wire logic rst_i,
	input dcache_pkg::line_need_t line_need_i,
	input dcache_pkg::beat_note_t beat_note_i,
	input dcache_pkg::bus_resp_t bus_resp_i,
	output logic line_done_o,
	output logic [dcache_pkg::LINE_W-1:0] line_dat_o
);
	import dcache_pkg::*;

	logic active_q;
	logic [BEATS-1:0] need_q;
	logic [BEATS-1:0] done_q;
	// quarters whose load beat has been taken
	logic [BEATS-1:0] noted_q;
	logic [TID_W-1:0] exp_tid_q [BEATS];
	logic [LINE_W-1:0] line_q;

	logic active_nxt;
	logic [BEATS-1:0] need_nxt;
	logic [BEATS-1:0] done_nxt;
	logic [BEATS-1:0] noted_nxt;
	logic [BEATS-1:0] hit;
	logic complete;

	// ==========================================================
	// matching
	// ==========================================================
	always_comb begin
		for (int q = 0; q < BEATS; q++)
			hit[q] = bus_resp_i.ack && !line_need_i.valid && noted_q[q] && !done_q[q] &&
				(exp_tid_q[q] == bus_resp_i.tid);
	end

	always_comb begin
		active_nxt = active_q | line_need_i.valid;
		need_nxt = line_need_i.valid ? line_need_i.need : need_q;
		done_nxt = line_need_i.valid ? '0 : (done_q | hit);
		noted_nxt = line_need_i.valid ? '0 : noted_q;
		// a note can land in the same cycle as the line start
		if (beat_note_i.valid)
			noted_nxt[beat_note_i.quarter] = 1'b1;
	end

	assign complete = active_nxt && (done_nxt == need_nxt);

	// ==========================================================
	// tracking state
	// ==========================================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			active_q <= 1'b0;
			need_q <= '0;
			done_q <= '0;
			noted_q <= '0;
			line_done_o <= 1'b0;
		end else begin
			need_q <= need_nxt;
			done_q <= done_nxt;
			noted_q <= noted_nxt;
			// one pulse, then idle until the next line
			line_done_o <= complete;
			active_q <= active_nxt && !complete;
		end
	end

	always_ff @(posedge clk_i) begin
		if (beat_note_i.valid)
			exp_tid_q[beat_note_i.quarter] <= beat_note_i.tid;
	end

	// unselected quarters read back as zero
	always_ff @(posedge clk_i) begin
		if (line_need_i.valid)
			line_q <= '0;
		for (int q = 0; q < BEATS; q++)
			if (hit[q])
				line_q[q*BEAT_W +: BEAT_W] <= bus_resp_i.dat;
	end

	assign line_dat_o = line_q;

endmodule

`default_nettype wire

//--- hw/dcache_line_merge.sv
// ==========================================================
// line merge
// byte merge of cpu write data over the loaded line
// cache write, cpu ack and queue release
// ==========================================================
`default_nettype none

module dcache_line_merge (
	input wire logic clk_i,
	input wire logic rst_i,
	input dcache_pkg::line_req_t head_i,
	input wire logic line_done_i,
	input wire logic [dcache_pkg::LINE_W-1:0] line_dat_i,
	output dcache_pkg::cache_wr_t cache_wr_o,
	output dcache_pkg::cpu_resp_t cpu_resp_o,
	output logic head_pop_o
);
	import dcache_pkg::*;

	logic [LINE_W-1:0] merged;

	// ==========================================================
	// byte merge
	// ==========================================================
	// writes take the cpu byte where sel is set, reads pass through
	always_comb begin
		for (int b = 0; b < LINE_BYTES; b++) begin
			if (head_i.we && head_i.sel[b])
				merged[b*8 +: 8] = head_i.dat[b*8 +: 8];
			else
				merged[b*8 +: 8] = line_dat_i[b*8 +: 8];
		end
	end

	// ==========================================================
	// completion outputs
	// ==========================================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			cache_wr_o.wr <= 1'b0;
			cpu_resp_o.ack <= 1'b0;
			head_pop_o <= 1'b0;
		end else begin
			// strobes last one cycle
			cache_wr_o.wr <= line_done_i && head_i.cacheable;
			cpu_resp_o.ack <= line_done_i;
			head_pop_o <= line_done_i;
			if (line_done_i) begin
				cache_wr_o.adr <= head_i.adr;
				cache_wr_o.dat <= merged;
				cpu_resp_o.tid <= head_i.tid;
				cpu_resp_o.dat <= merged;
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/dcache_ctrl_top.sv
// ==========================================================
// data cache miss controller top level
// queue, beat issuer, response collector and line merge
// ==========================================================
`default_nettype none

module dcache_ctrl_top (
	input wire logic clk_i,
	input wire logic rst_i,
	input dcache_pkg::line_req_t cpu_req_i,
	output logic cpu_busy_o,
	output dcache_pkg::bus_req_t bus_req_o,
	input wire logic bus_full_i,
	input dcache_pkg::bus_resp_t bus_resp_i,
	output dcache_pkg::cache_wr_t cache_wr_o,
	output dcache_pkg::cpu_resp_t cpu_resp_o
);
	import dcache_pkg::*;

	// head entry, shared by issuer and merge
	line_req_t head;
	logic head_pop;
	line_need_t line_need;
	beat_note_t beat_note;
	logic line_done;
	logic [LINE_W-1:0] line_dat;

	dcache_req_queue req_queue_i (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.cpu_req_i(cpu_req_i),
		.head_pop_i(head_pop),
		.head_o(head),
		.busy_o(cpu_busy_o)
	);

	dcache_beat_issuer beat_issuer_i (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.head_i(head),
		.head_pop_i(head_pop),
		.bus_full_i(bus_full_i),
		.bus_req_o(bus_req_o),
		.line_need_o(line_need),
		.beat_note_o(beat_note)
	);

	dcache_beat_collector beat_collector_i (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.line_need_i(line_need),
		.beat_note_i(beat_note),
		.bus_resp_i(bus_resp_i),
		.line_done_o(line_done),
		.line_dat_o(line_dat)
	);

	// completion releases the head back to queue and issuer
	dcache_line_merge line_merge_i (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.head_i(head),
		.line_done_i(line_done),
		.line_dat_i(line_dat),
		.cache_wr_o(cache_wr_o),
		.cpu_resp_o(cpu_resp_o),
		.head_pop_o(head_pop)
	);

endmodule

`default_nettype wire

//--- dv/dcache_tb.sv
// ==========================================================
// testbench for the data cache miss controller
// clock, reset, memory responder, directed tests
// typed compare tasks and closing summary
// ==========================================================
`default_nettype none

module dcache_tb;
	import dcache_pkg::*;

	// eleven cpu strobes over all tests
	localparam int REQ_COUNT = 11;
	localparam int CYCLE_LIMIT = 400 * REQ_COUNT;

	logic clk;
	logic rst;
	line_req_t cpu_req;
	logic cpu_busy;
	bus_req_t bus_req;
	logic bus_full;
	bus_resp_t bus_resp;
	cache_wr_t cache_wr;
	cpu_resp_t cpu_resp;

	// memory model with one 128-bit beat per entry indexed by adr[11:4]
	logic [BEAT_W-1:0] mem [256];

	// responder state
	bus_resp_t pend_q [$];
	int pend_wait [$];
	logic reverse_resp;
	logic full_rand;
	logic bus_idle;

	// observed and expected traffic
	bus_req_t beat_log [$];
	cpu_resp_t resp_log [$];
	cache_wr_t cwr_log [$];
	bus_req_t exp_beats [$];
	cpu_resp_t exp_resp [$];
	cache_wr_t exp_cwr [$];
	logic [TID_W-1:0] next_tid;

	int n_checks;
	int n_errors;
	int cycles;

	dcache_ctrl_top dcache_ctrl_top_i (
		.clk_i(clk),
		.rst_i(rst),
		.cpu_req_i(cpu_req),
		.cpu_busy_o(cpu_busy),
		.bus_req_o(bus_req),
		.bus_full_i(bus_full),
		.bus_resp_i(bus_resp),
		.cache_wr_o(cache_wr),
		.cpu_resp_o(cpu_resp)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ==========================================================
	// reference helpers
	// ==========================================================
	// initial memory contents as a function of the full beat address
	function automatic logic [BEAT_W-1:0] fill_beat(logic [ADR_W-1:0] adr);
		logic [BEAT_W-1:0] v;
		for (int w = 0; w < 4; w++)
			v[w*32 +: 32] = (adr ^ 32'h5a3c_0000) * 32'h0100_0193 + 32'(w) * 32'h9e37_79b9;
		return v;
	endfunction

	function automatic logic [LINE_W-1:0] rand_line();
		logic [LINE_W-1:0] v;
		for (int w = 0; w < LINE_W / 32; w++)
			v[w*32 +: 32] = $urandom();
		return v;
	endfunction

	// fill pattern in the loaded quarters and zero in the rest
	// writes then lay the cpu bytes on top
	function automatic logic [LINE_W-1:0] expect_line(line_req_t r);
		logic [LINE_W-1:0] v;
		logic q_sel;
		v = '0;
		for (int q = 0; q < BEATS; q++) begin
			q_sel = |r.sel[q*BEAT_BYTES +: BEAT_BYTES];
			if (r.cacheable || (!r.we && q_sel))
				v[q*BEAT_W +: BEAT_W] = fill_beat(r.adr + ADR_W'(q * BEAT_BYTES));
		end
		for (int b = 0; b < LINE_BYTES; b++)
			if (r.we && r.sel[b])
				v[b*8 +: 8] = r.dat[b*8 +: 8];
		return v;
	endfunction

	function automatic line_req_t make_req(logic [TID_W-1:0] tid, logic we, logic cacheable,
			logic [ADR_W-1:0] adr, logic [LINE_BYTES-1:0] sel);
		line_req_t r;
		r.cyc = 1'b1;
		r.tid = tid;
		r.we = we;
		r.cacheable = cacheable;
		r.adr = adr;
		r.sel = sel;
		r.dat = rand_line();
		return r;
	endfunction

	// bus ids count up per beat and skip 0
	function automatic bus_req_t make_beat(bus_cmd_e cmd, logic [ADR_W-1:0] adr,
			logic [BEAT_BYTES-1:0] sel, logic [BEAT_W-1:0] dat);
		bus_req_t b;
		b.cyc = 1'b1;
		b.cmd = cmd;
		b.tid = next_tid;
		b.adr = adr;
		b.sel = sel;
		b.dat = dat;
		next_tid = (next_tid == 4'd15) ? 4'd1 : next_tid + 4'd1;
		return b;
	endfunction

	// queue the beats, ack and cache write a request should produce
	task automatic expect_request(line_req_t r);
		logic [BEAT_BYTES-1:0] qs;
		logic [ADR_W-1:0] qa;
		cpu_resp_t rs;
		cache_wr_t cw;
		for (int q = 0; q < BEATS; q++) begin
			qs = r.sel[q*BEAT_BYTES +: BEAT_BYTES];
			qa = r.adr + ADR_W'(q * BEAT_BYTES);
			if (r.we && qs != '0)
				exp_beats.push_back(make_beat(CMD_STORE, qa, qs, r.dat[q*BEAT_W +: BEAT_W]));
		end
		for (int q = 0; q < BEATS; q++) begin
			qs = r.sel[q*BEAT_BYTES +: BEAT_BYTES];
			qa = r.adr + ADR_W'(q * BEAT_BYTES);
			if (r.cacheable)
				exp_beats.push_back(make_beat(CMD_LINE_LOAD, qa, '1, '0));
			else if (!r.we && qs != '0)
				exp_beats.push_back(make_beat(CMD_LOAD, qa, qs, '0));
		end
		rs.ack = 1'b1;
		rs.tid = r.tid;
		rs.dat = expect_line(r);
		exp_resp.push_back(rs);
		if (r.cacheable) begin
			cw.wr = 1'b1;
			cw.adr = r.adr;
			cw.dat = rs.dat;
			exp_cwr.push_back(cw);
		end
	endtask

	// ==========================================================
	// compare tasks
	// ==========================================================
	task automatic check_bus_req(string what, bus_req_t exp, bus_req_t act);
		n_checks++;
		if (exp !== act) begin
			n_errors++;
			$display("ERROR at %0t: %s: expected %h, got %h", $time, what, exp, act);
		end
	endtask

	task automatic check_cpu_resp(string what, cpu_resp_t exp, cpu_resp_t act);
		n_checks++;
		if (exp !== act) begin
			n_errors++;
			$display("ERROR at %0t: %s: expected %h, got %h", $time, what, exp, act);
		end
	endtask

	task automatic check_cache_wr(string what, cache_wr_t exp, cache_wr_t act);
		n_checks++;
		if (exp !== act) begin
			n_errors++;
			$display("ERROR at %0t: %s: expected %h, got %h", $time, what, exp, act);
		end
	endtask

	// single control bits, x or z counts as wrong
	task automatic check_flag(string what, logic exp, logic act);
		n_checks++;
		if (exp !== act) begin
			n_errors++;
			$display("ERROR at %0t: %s: expected %b, got %b", $time, what, exp, act);
		end
	endtask

	task automatic check_count(string what, int exp, int act);
		n_checks++;
		if (exp != act) begin
			n_errors++;
			$display("ERROR at %0t: %s: expected %0d, got %0d", $time, what, exp, act);
		end
	endtask

	// compare everything seen since the last call and then start over
	task automatic check_logs(string name);
		check_count({name, " beat count"}, exp_beats.size(), beat_log.size());
		for (int i = 0; i < exp_beats.size() && i < beat_log.size(); i++)
			check_bus_req({name, " beat"}, exp_beats[i], beat_log[i]);
		check_count({name, " ack count"}, exp_resp.size(), resp_log.size());
		for (int i = 0; i < exp_resp.size() && i < resp_log.size(); i++)
			check_cpu_resp({name, " cpu ack"}, exp_resp[i], resp_log[i]);
		check_count({name, " cache write count"}, exp_cwr.size(), cwr_log.size());
		for (int i = 0; i < exp_cwr.size() && i < cwr_log.size(); i++)
			check_cache_wr({name, " cache write"}, exp_cwr[i], cwr_log[i]);
		exp_beats.delete();
		beat_log.delete();
		exp_resp.delete();
		resp_log.delete();
		exp_cwr.delete();
		cwr_log.delete();
	endtask

	// ==========================================================
	// stimulus helpers
	// ==========================================================
	// step to the drive point just after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic send_req(line_req_t r);
		while (cpu_busy)
			next_cycle();
		cpu_req = r;
		cpu_req.cyc = 1'b1;
		next_cycle();
		cpu_req.cyc = 1'b0;
	endtask

	task automatic wait_acks(int n);
		while (resp_log.size() < n)
			next_cycle();
	endtask

	// ==========================================================
	// bus monitor and memory responder
	// ==========================================================
	// sampled at the falling edge where every input and output is settled
	initial begin
		bus_resp_t r;
		bus_req_t prev;
		logic prev_stall;
		logic [7:0] idx;
		prev = '0;
		prev_stall = 1'b0;
		bus_idle = 1'b1;
		for (int i = 0; i < 256; i++)
			mem[i] = fill_beat({20'h0, 8'(i), 4'h0});
		forever begin
			@(negedge clk);
			if (prev_stall)
				check_bus_req("beat held under bus_full", prev, bus_req);
			prev_stall = bus_req.cyc && bus_full;
			prev = bus_req;
			bus_idle = !bus_req.cyc;
			if (bus_req.cyc && !bus_full) begin
				beat_log.push_back(bus_req);
				idx = bus_req.adr[11:4];
				if (bus_req.cmd == CMD_STORE) begin
					for (int b = 0; b < BEAT_BYTES; b++)
						if (bus_req.sel[b])
							mem[idx][b*8 +: 8] = bus_req.dat[b*8 +: 8];
				end else begin
					r.ack = 1'b1;
					r.tid = bus_req.tid;
					r.adr = bus_req.adr;
					r.dat = mem[idx];
					pend_q.push_back(r);
					pend_wait.push_back($urandom_range(0, 6));
				end
			end
			if (cpu_resp.ack)
				resp_log.push_back(cpu_resp);
			if (cache_wr.wr)
				cwr_log.push_back(cache_wr);
		end
	end

	// one ack per cycle after a random delay
	initial begin
		int pick;
		bus_resp = '0;
		forever begin
			next_cycle();
			bus_resp = '0;
			pick = -1;
			for (int i = 0; i < pend_wait.size(); i++)
				if (pend_wait[i] > 0)
					pend_wait[i] = pend_wait[i] - 1;
			// reverse mode holds acks until the issuer goes quiet and returns the newest first
			if (reverse_resp) begin
				if (pend_q.size() > 0 && bus_idle && pend_wait[$] == 0)
					pick = pend_q.size() - 1;
			end else begin
				for (int i = 0; i < pend_q.size(); i++)
					if (pick < 0 && pend_wait[i] == 0)
						pick = i;
			end
			if (pick >= 0) begin
				bus_resp = pend_q[pick];
				pend_q.delete(pick);
				pend_wait.delete(pick);
			end
		end
	end

	initial begin
		bus_full = 1'b0;
		forever begin
			next_cycle();
			bus_full = full_rand ? 1'($urandom_range(0, 1)) : 1'b0;
		end
	end

	// watchdog
	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: no completion within %0d cycles", CYCLE_LIMIT);
		$display("Checks failed");
		$finish;
	end

	// ==========================================================
	// directed tests
	// ==========================================================
	task automatic test_reset_state();
		check_flag("busy after reset", 1'b0, cpu_busy);
		check_flag("bus cyc after reset", 1'b0, bus_req.cyc);
		check_flag("cache wr after reset", 1'b0, cache_wr.wr);
		check_flag("cpu ack after reset", 1'b0, cpu_resp.ack);
	endtask

	task automatic test_cacheable_read();
		line_req_t r;
		r = make_req(4'd1, 1'b0, 1'b1, 32'h0000_0040, '1);
		expect_request(r);
		send_req(r);
		wait_acks(1);
		check_logs("cacheable read");
	endtask

	task automatic test_uncached_read();
		line_req_t r;
		// quarters 0 and 2 only
		r = make_req(4'd2, 1'b0, 1'b0, 32'h0000_0080, 64'h0000_00f0_0000_8001);
		expect_request(r);
		send_req(r);
		wait_acks(1);
		check_logs("uncached read");
	endtask

	task automatic test_cacheable_write();
		line_req_t r;
		r = make_req(4'd3, 1'b1, 1'b1, 32'h0000_00c0, 64'h0f00_0000_00ff_0000);
		expect_request(r);
		send_req(r);
		wait_acks(1);
		check_logs("cacheable write");
	endtask

	task automatic test_uncached_write();
		line_req_t r;
		r = make_req(4'd4, 1'b1, 1'b0, 32'h0000_0100, 64'hc000_0000_ffff_0003);
		expect_request(r);
		send_req(r);
		wait_acks(1);
		check_logs("uncached write");
	endtask

	task automatic test_backpressure();
		line_req_t rd;
		line_req_t wr;
		full_rand = 1'b1;
		reverse_resp = 1'b1;
		rd = make_req(4'd5, 1'b0, 1'b1, 32'h0000_0140, '1);
		expect_request(rd);
		send_req(rd);
		wait_acks(1);
		wr = make_req(4'd6, 1'b1, 1'b1, 32'h0000_0180, 64'h0000_1234_0000_0001);
		expect_request(wr);
		send_req(wr);
		wait_acks(2);
		full_rand = 1'b0;
		reverse_resp = 1'b0;
		check_logs("back-pressure");
	endtask

	task automatic test_queue();
		line_req_t r [4];
		line_req_t dup;
		r[0] = make_req(4'd3, 1'b0, 1'b1, 32'h0000_0200, '1);
		r[1] = make_req(4'd5, 1'b0, 1'b1, 32'h0000_0240, '1);
		r[2] = make_req(4'd7, 1'b0, 1'b1, 32'h0000_0280, '1);
		r[3] = make_req(4'd9, 1'b0, 1'b1, 32'h0000_02c0, '1);
		for (int i = 0; i < 4; i++) begin
			expect_request(r[i]);
			send_req(r[i]);
		end
		check_flag("busy with four queued", 1'b1, cpu_busy);
		// same tid as the last queued entry so it must be dropped
		dup = make_req(4'd9, 1'b0, 1'b1, 32'h0000_0300, '1);
		send_req(dup);
		wait_acks(4);
		// quiet window to catch a stray ack
		repeat (40)
			next_cycle();
		check_logs("queue");
	endtask

	// ==========================================================
	// main sequence
	// ==========================================================
	initial begin
		void'($urandom(32'hb13a4f5c));
		rst = 1'b1;
		cpu_req = '0;
		full_rand = 1'b0;
		reverse_resp = 1'b0;
		next_tid = 4'd1;
		n_checks = 0;
		n_errors = 0;
		repeat (8)
			@(posedge clk);
		#1;
		rst = 1'b0;
		next_cycle();
		test_reset_state();
		test_cacheable_read();
		test_uncached_read();
		test_cacheable_write();
		test_uncached_write();
		test_backpressure();
		test_queue();
		$display("summary: %0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
hw/dcache_pkg.sv
hw/dcache_req_queue.sv
hw/dcache_beat_issuer.sv
hw/dcache_beat_collector.sv
hw/dcache_line_merge.sv
hw/dcache_ctrl_top.sv
dv/dcache_tb.sv
